// File: hw/scale_pkg.sv
package scale_pkg;

  // scan codes, top bit marks an extended key
  localparam int scan_w = 9;

  localparam logic [scan_w-1:0] key_enter     = 9'h05a;
  localparam logic [scan_w-1:0] key_enter_ext = 9'h15a; // keypad enter
  localparam logic [scan_w-1:0] key_asc       = 9'h045; // 0
  localparam logic [scan_w-1:0] key_asc_pad   = 9'h070;
  localparam logic [scan_w-1:0] key_dsc       = 9'h016; // 1
  localparam logic [scan_w-1:0] key_dsc_pad   = 9'h069;
  localparam logic [scan_w-1:0] key_spd       = 9'h01e; // 2
  localparam logic [scan_w-1:0] key_spd_pad   = 9'h072;

  // C4 up to C8
  localparam int tone_count = 29;
  localparam int tone_w     = 5;

  localparam logic [tone_w-1:0] tone_highest = 5'd28;
  localparam logic [tone_w-1:0] tone_lowest  = 5'd0;

  localparam logic [31:0] freq_invalid = 32'd10000; // obviously wrong pitch

  // octave 4, C through B, in Hz
  localparam logic [31:0] note_base [7] = '{
    32'd262,
    32'd294,
    32'd330,
    32'd349,
    32'd392,
    32'd440,
    32'd494
  };

  // one octave up per group of seven tones
  function automatic logic [31:0] note_freq(input logic [tone_w-1:0] idx);
    logic [2:0] note;
    logic [2:0] octave;
    begin
      note   = 3'(idx % 7);
      octave = 3'(idx / 7);
      if (idx > tone_highest)
        note_freq = freq_invalid;
      else
        note_freq = note_base[note] << octave;
    end
  endfunction

endpackage

// File: hw/key_command_decoder.sv
`timescale 1ns/1ps

module key_command_decoder
  import scale_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [scan_w-1:0] scan_code,
  input  logic              scan_valid,
  input  logic              scan_make,
  output logic              clear,
  output logic              asc,
  output logic              dsc,
  output logic              spd_toggle
);

  logic press;
  logic hit_enter;
  logic hit_asc;
  logic hit_dsc;
  logic hit_spd;

  assign press = scan_valid && scan_make; // break codes ignored

  // each command answers to the main key and its keypad twin
  assign hit_enter = (scan_code == key_enter) || (scan_code == key_enter_ext);
  assign hit_asc   = (scan_code == key_asc) || (scan_code == key_asc_pad);
  assign hit_dsc   = (scan_code == key_dsc) || (scan_code == key_dsc_pad);
  assign hit_spd   = (scan_code == key_spd) || (scan_code == key_spd_pad);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clear      <= 1'b0;
      asc        <= 1'b0;
      dsc        <= 1'b0;
      spd_toggle <= 1'b0;
    end
    else
    begin
      // pulses last one cycle, drop without a fresh press
      clear      <= press && hit_enter;
      asc        <= press && hit_asc;
      dsc        <= press && hit_dsc;
      spd_toggle <= press && hit_spd;
    end
  end

  // downstream blocks assume one command at a time
  a_one_command: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({clear, asc, dsc, spd_toggle})
  );

endmodule

// File: hw/beat_timer.sv
`timescale 1ns/1ps

module beat_timer #(
  parameter int unsigned beat_short = 50_000_000, // cycles per beat, fast
  parameter int unsigned beat_long  = 100_000_000
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic spd_toggle,
  output logic speed_state,
  output logic beat
);

  logic [31:0] cnt;
  logic [31:0] interval;
  logic        wrap;

  assign interval = speed_state ? beat_long : beat_short;

  // >= also catches a count left over from the long interval
  assign wrap = (cnt >= interval - 32'd1);
  assign beat = wrap;

  // 0 is the short interval
  always_ff @(posedge clk)
  begin
    if (rst || clear)
      speed_state <= 1'b0;
    else if (spd_toggle)
      speed_state <= ~speed_state;
  end

  always_ff @(posedge clk)
  begin
    if (rst || clear)
      cnt <= 32'd0;
    else if (wrap)
      cnt <= 32'd0;
    else
      cnt <= cnt + 32'd1;
  end

  // the long interval bounds the counter in either speed
  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    cnt <= beat_long - 32'd1
  );

endmodule

// File: hw/tone_stepper.sv
`timescale 1ns/1ps

module tone_stepper
  import scale_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              clear,
  input  logic              asc,
  input  logic              dsc,
  input  logic              beat,
  output logic [tone_w-1:0] tone_idx
);

  logic              ascending;
  logic [tone_w-1:0] next_idx;

  // asc wins over dsc
  always_ff @(posedge clk)
  begin
    if (rst || clear)
      ascending <= 1'b1;
    else if (asc)
      ascending <= 1'b1;
    else if (dsc)
      ascending <= 1'b0;
  end

  // saturating step in the current direction
  always_comb
  begin
    if (ascending)
    begin
      if (tone_idx >= tone_highest)
        next_idx = tone_highest;
      else
        next_idx = tone_idx + 5'd1;
    end
    else
    begin
      if (tone_idx == tone_lowest)
        next_idx = tone_lowest;
      else
        next_idx = tone_idx - 5'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || clear)
      tone_idx <= tone_lowest;
    else if (beat)
      tone_idx <= next_idx; // direction from before any same-cycle command
  end

  a_idx_range: assert property (
    @(posedge clk) disable iff (rst)
    tone_idx <= tone_highest
  );

endmodule

// File: hw/tone_pwm.sv
`timescale 1ns/1ps

module tone_pwm
  import scale_pkg::*;
#(
  parameter int unsigned clk_hz = 100_000_000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clear,
  input  logic [tone_w-1:0] tone_idx,
  output logic              audio_pwm
);

  logic [31:0]       period_tab [tone_count];
  logic [tone_w-1:0] tone_lat;
  logic [31:0]       period;
  logic [31:0]       half;
  logic [31:0]       cnt;
  logic              period_end;

  // period in clock cycles for each tone, folded to constants
  for (genvar i = 0; i < tone_count; i++)
  begin : g_period
    assign period_tab[i] = clk_hz / note_freq(tone_w'(i));
  end

  assign period     = period_tab[tone_lat];
  assign half       = period >> 1;
  assign period_end = (cnt >= period - 32'd1);

  // new tone only takes over at a period boundary
  always_ff @(posedge clk)
  begin
    if (rst || clear)
      tone_lat <= tone_lowest; // where the stepper lands after clear
    else if (period_end)
      tone_lat <= tone_idx;
  end

  always_ff @(posedge clk)
  begin
    if (rst || clear)
      cnt <= 32'd0;
    else if (period_end)
      cnt <= 32'd0;
    else
      cnt <= cnt + 32'd1;
  end

  // high for the first half, one cycle behind the count
  always_ff @(posedge clk)
  begin
    if (rst || clear)
      audio_pwm <= 1'b0;
    else
      audio_pwm <= (cnt < half);
  end

  // the period table only covers the stepper's range
  a_lat_range: assert property (
    @(posedge clk) disable iff (rst)
    tone_lat <= tone_highest
  );

endmodule

// File: hw/musical_scale_top.sv
`timescale 1ns/1ps

module musical_scale_top
  import scale_pkg::*;
#(
  parameter int unsigned clk_hz     = 100_000_000,
  parameter int unsigned beat_short = 50_000_000,
  parameter int unsigned beat_long  = 100_000_000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [scan_w-1:0] scan_code,
  input  logic              scan_valid,
  input  logic              scan_make,
  output logic              audio_pwm,
  output logic [tone_w-1:0] tone_idx,
  output logic              speed_state
);

  logic clear;
  logic asc;
  logic dsc;
  logic spd_toggle;
  logic beat;

  key_command_decoder key_command_decoder_inst (
    .clk        (clk),
    .rst        (rst),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .scan_make  (scan_make),
    .clear      (clear),
    .asc        (asc),
    .dsc        (dsc),
    .spd_toggle (spd_toggle)
  );

  beat_timer #(
    .beat_short (beat_short),
    .beat_long  (beat_long)
  ) beat_timer_inst (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .spd_toggle  (spd_toggle),
    .speed_state (speed_state),
    .beat        (beat)
  );

  tone_stepper tone_stepper_inst (
    .clk      (clk),
    .rst      (rst),
    .clear    (clear),
    .asc      (asc),
    .dsc      (dsc),
    .beat     (beat),
    .tone_idx (tone_idx)
  );

  tone_pwm #(
    .clk_hz (clk_hz)
  ) tone_pwm_inst (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .tone_idx  (tone_idx),
    .audio_pwm (audio_pwm)
  );

endmodule

// File: sim/musical_scale_tb.sv
`timescale 1ns/1ps

module musical_scale_tb
  import scale_pkg::*;
();

  localparam int clk_hz     = 1_000_000;
  localparam int beat_short = 40;
  localparam int beat_long  = 80;
  localparam int num_steps  = 12;

  logic              clk;
  logic              rst;
  logic [scan_w-1:0] scan_code;
  logic              scan_valid;
  logic              scan_make;
  logic              audio_pwm;
  logic [tone_w-1:0] tone_idx;
  logic              speed_state;

  // stimulus table with one array per column
  string             step_name  [num_steps];
  logic [scan_w-1:0] step_code  [num_steps];
  logic              step_make  [num_steps];
  int                step_rand  [num_steps];
  int                step_beats [num_steps];
  int                step_tone  [num_steps];
  int                step_speed [num_steps];
  int                step_gap   [num_steps];
  logic              step_meas  [num_steps];
  int                step_fill;

  int     cycle = 0;
  int     cycle_limit = 1_000_000;
  int     checks;
  int     errors;
  integer seed;

  int model_idx; // reference model of the stepper
  int model_up;
  int model_speed;

  musical_scale_top #(
    .clk_hz     (clk_hz),
    .beat_short (beat_short),
    .beat_long  (beat_long)
  ) musical_scale_top_inst (
    .clk         (clk),
    .rst         (rst),
    .scan_code   (scan_code),
    .scan_valid  (scan_valid),
    .scan_make   (scan_make),
    .audio_pwm   (audio_pwm),
    .tone_idx    (tone_idx),
    .speed_state (speed_state)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("timeout after %0d cycles, the table never finished", cycle);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic add_step(input string name, input logic [scan_w-1:0] code, input logic make,
                          input int rand_n, input int beats, input int tone, input int speed,
                          input int gap, input logic meas);
    step_name[step_fill]  = name;
    step_code[step_fill]  = code;
    step_make[step_fill]  = make;
    step_rand[step_fill]  = rand_n;
    step_beats[step_fill] = beats;
    step_tone[step_fill]  = tone;
    step_speed[step_fill] = speed;
    step_gap[step_fill]   = gap;
    step_meas[step_fill]  = meas;
    step_fill++;
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected)
    else
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  // octave 4 base times two per octave
  function automatic int tone_hz(input int idx);
    int base;
    case (idx % 7)
      0: base = 262;
      1: base = 294;
      2: base = 330;
      3: base = 349;
      4: base = 392;
      5: base = 440;
      default: base = 494;
    endcase
    tone_hz = base << (idx / 7);
  endfunction

  function automatic logic is_command_key(input logic [scan_w-1:0] code);
    is_command_key = (code == key_enter) || (code == key_enter_ext) ||
                     (code == key_asc) || (code == key_asc_pad) ||
                     (code == key_dsc) || (code == key_dsc_pad) ||
                     (code == key_spd) || (code == key_spd_pad);
  endfunction

  task automatic pick_unrelated(output logic [scan_w-1:0] code);
    int r;
    r = $random(seed);
    while (is_command_key(r[8:0]))
      r = $random(seed);
    code = r[8:0];
  endtask

  // saturating step rule
  task automatic step_model();
    if (model_up != 0 && model_idx < int'(tone_highest))
      model_idx++;
    else if (model_up == 0 && model_idx > int'(tone_lowest))
      model_idx--;
  endtask

  // counts beat pulses and checks every step and the spacing of tone changes
  task automatic wait_beats(input int n, input string name, input int exp_gap);
    int seen;
    int changes;
    int last_change;
    int gap;
    logic was_beat;
    logic [tone_w-1:0] prev;
    seen = 0;
    changes = 0;
    last_change = 0;
    gap = 0;
    prev = tone_idx;
    while (seen < n)
    begin
      was_beat = musical_scale_top_inst.beat;
      @(posedge clk);
      #5;
      if (tone_idx != prev)
      begin
        if (changes > 0)
          gap = cycle - last_change;
        changes++;
        last_change = cycle;
        prev = tone_idx;
      end
      if (was_beat)
      begin
        seen++;
        step_model();
        check_value({name, " step"}, model_idx, int'(tone_idx));
      end
    end
    if (exp_gap != 0)
      check_value({name, " beat spacing"}, exp_gap, gap);
  endtask

  task automatic apply_key(input int i);
    logic [scan_w-1:0] code;
    logic [scan_w-1:0] noise;
    code = step_code[i];
    scan_code  = code;
    scan_make  = step_make[i];
    scan_valid = 1'b1;
    if (step_make[i])
    begin
      if (code == key_enter || code == key_enter_ext)
      begin
        model_idx = 0;
        model_up = 1;
        model_speed = 0;
      end
      else if (code == key_asc || code == key_asc_pad)
        model_up = 1;
      else if (code == key_dsc || code == key_dsc_pad)
        model_up = 0;
      else if (code == key_spd || code == key_spd_pad)
        model_speed = 1 - model_speed;
    end
    @(posedge clk);
    #5;
    for (int k = 0; k < step_rand[i]; k++)
    begin
      pick_unrelated(noise);
      scan_code = noise;
      scan_make = 1'b1;
      @(posedge clk);
      #5;
    end
    scan_valid = 1'b0;
    scan_make  = 1'b0;
    @(posedge clk);
    #5;
    check_value({step_name[i], " speed after key"}, model_speed, int'(speed_state));
    check_value({step_name[i], " tone after key"}, model_idx, int'(tone_idx));
  endtask

  // skips the first rise and measures the next full period
  task automatic measure_pwm(input string name, input int idx);
    int rises;
    int r2;
    int r3;
    int f2;
    logic prev;
    rises = 0;
    r2 = 0;
    r3 = 0;
    f2 = 0;
    prev = audio_pwm;
    while (rises < 3)
    begin
      @(posedge clk);
      #5;
      if (!prev && audio_pwm)
      begin
        rises++;
        if (rises == 2)
          r2 = cycle;
        if (rises == 3)
          r3 = cycle;
      end
      if (prev && !audio_pwm && rises == 2)
        f2 = cycle;
      prev = audio_pwm;
    end
    check_value({name, " pwm period"}, clk_hz / tone_hz(idx), r3 - r2);
    check_value({name, " pwm high"}, (clk_hz / tone_hz(idx)) / 2, f2 - r2);
  endtask

  initial
  begin
    rst = 1'b1;
    scan_code = '0;
    scan_valid = 1'b0;
    scan_make = 1'b0;
    seed = 94;
    checks = 0;
    errors = 0;
    step_fill = 0;
    model_idx = 0;
    model_up = 1;
    model_speed = 0;

    //       name                  code           make  rnd beats tone spd gap  pwm
    add_step("rise_to_top",        key_asc,       1'b0, 0,  30,   28,  0,  40,  1'b1);
    add_step("fall_to_bottom",     key_dsc,       1'b1, 0,  30,   0,   0,  40,  1'b1);
    add_step("reverse_up",         key_asc_pad,   1'b1, 0,  5,    5,   0,  40,  1'b0);
    add_step("speed_slow",         key_spd,       1'b1, 0,  4,    10,  1,  80,  1'b0);
    add_step("speed_fast",         key_spd_pad,   1'b1, 0,  4,    15,  0,  40,  1'b0);
    add_step("break_dsc",          key_dsc,       1'b0, 0,  3,    19,  0,  40,  1'b0);
    add_step("break_spd",          key_spd_pad,   1'b0, 0,  3,    23,  0,  40,  1'b0);
    add_step("random_codes",       key_enter,     1'b0, 8,  3,    27,  0,  40,  1'b0);
    add_step("slow_again",         key_spd,       1'b1, 0,  1,    28,  1,  0,   1'b0);
    add_step("clear_keypad",       key_enter_ext, 1'b1, 0,  4,    4,   0,  40,  1'b0);
    add_step("fall_keypad",        key_dsc_pad,   1'b1, 0,  2,    3,   0,  40,  1'b0);
    add_step("clear_main",         key_enter,     1'b1, 0,  2,    2,   0,  40,  1'b0);

    // worst case beat length plus the pwm windows
    cycle_limit = 2000;
    for (int i = 0; i < num_steps; i++)
    begin
      cycle_limit += (step_beats[i] + 1) * beat_long;
      if (step_meas[i])
        cycle_limit += 3 * (clk_hz / tone_hz(step_tone[i])) + clk_hz / tone_hz(0);
    end

    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;

    for (int i = 0; i < num_steps; i++)
    begin
      wait_beats(1, {step_name[i], " sync"}, 0); // press right after a beat
      apply_key(i);
      wait_beats(step_beats[i], step_name[i], step_gap[i]);
      check_value({step_name[i], " tone_idx"}, step_tone[i], int'(tone_idx));
      check_value({step_name[i], " speed_state"}, step_speed[i], int'(speed_state));
      if (step_meas[i])
        measure_pwm(step_name[i], step_tone[i]);
    end

    $display("checks run %0d, checks failed %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: list.f
hw/scale_pkg.sv
hw/key_command_decoder.sv
hw/beat_timer.sv
hw/tone_stepper.sv
hw/tone_pwm.sv
hw/musical_scale_top.sv
sim/musical_scale_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the musical scale testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=musical_scale_sim
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module musical_scale_tb \
  -f list.f \
  --Mdir "$build_dir" -o "$sim_exe"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Regression passed$" "$log_file"; then
  exit 0
else
  echo "pass message not found in $log_file"
  exit 1
fi
